// File: src/dot_pkg.sv
// Shared widths, latencies, credit counts and payload types of the dot-product unit
`default_nettype none

package dot_pkg;

   // --------------------
   // Datapath widths
   // --------------------
   localparam int elem_w = 8;
   localparam int vec_len = 4;
   localparam int acc_w = 32;
   // Full signed product of two elements
   localparam int prod_w = 2 * elem_w;
   // Two tree levels add one bit each
   localparam int sum_w = prod_w + 2;
   // Headroom for tree sum plus accumulator
   localparam int wide_w = acc_w + 2;

   // --------------------
   // Pipeline timing
   // --------------------
   localparam int mult_latency = 2;
   localparam int tree_depth = 2;
   // Input reg, multiply, tree, combine
   localparam int pipe_latency = 1 + mult_latency + tree_depth + 1;

   // --------------------
   // Flow control
   // --------------------
   localparam int result_depth = 4;
   localparam int down_credits = 2;
   localparam int fifo_aw = $clog2(result_depth);
   // Room for every credit the sink could ever hand back
   localparam int credit_w = $clog2(result_depth + down_credits + 1);

   // Payload types
   typedef logic signed [elem_w-1:0] elem_t;
   typedef elem_t [vec_len-1:0] vec_t;
   typedef logic signed [acc_w-1:0] acc_t;
   typedef logic signed [sum_w-1:0] sum_t;
   typedef logic signed [wide_w-1:0] wide_t;

endpackage

`default_nettype wire

// File: src/pipe_delay.sv
// Fixed-depth register delay line for any payload type, cleared on reset
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
   parameter int DEPTH = 1,
   parameter type payload_t = logic
) (
   input  wire      clk,
   input  wire      rst_n,
   input  payload_t d,
   output payload_t q
);

   // One register per cycle of delay
   payload_t stage_q [DEPTH];

   // --------------------
   // Shift chain
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
         end
      end else begin
         // Head takes the new value
         stage_q[0] <= d;
         // Everything else moves one step along
         for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // Tail of the chain
   assign q = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: src/mult_stage.sv
// Signed element multiplier with a short register pipeline behind it
`timescale 1ns/1ps
`default_nettype none

module mult_stage
   import dot_pkg::*;
(
   input  wire                       clk,
   input  wire                       rst_n,
   input  elem_t                     a,
   input  elem_t                     b,
   output logic signed [prod_w-1:0]  p
);

   // Raw product, full width so nothing is lost
   logic signed [prod_w-1:0] prod;
   // Registers after the multiplier, retimed into the DSP by synthesis
   logic signed [prod_w-1:0] prod_q [mult_latency];

   // Both operands are signed and extend to the product width
   assign prod = a * b;

   // --------------------
   // Product pipeline
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < mult_latency; i++) begin
            prod_q[i] <= '0;
         end
      end else begin
         prod_q[0] <= prod;
         for (int i = 1; i < mult_latency; i++) begin
            prod_q[i] <= prod_q[i-1];
         end
      end
   end

   // Last stage feeds the adder tree
   assign p = prod_q[mult_latency-1];

endmodule

`default_nettype wire

// File: src/product_tree.sv
// Element-wise multiply of two vectors followed by a registered two-level adder tree
`timescale 1ns/1ps
`default_nettype none

module product_tree
   import dot_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n,
   input  vec_t  a_vec,
   input  vec_t  b_vec,
   output sum_t  tree_sum
);

   // Input capture
   vec_t a_q;
   vec_t b_q;

   // Multiplier outputs, one per element
   logic signed [prod_w-1:0] prod [vec_len];

   // First tree level, one extra bit per pair
   logic signed [prod_w:0] pair_q [vec_len/2];

   // --------------------
   // Input registers
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_q <= '0;
         b_q <= '0;
      end else begin
         a_q <= a_vec;
         b_q <= b_vec;
      end
   end

   // --------------------
   // Multiplier array
   // --------------------
   for (genvar i = 0; i < vec_len; i++) begin : g_mult
      mult_stage u_mult (
         .clk   (clk),
         .rst_n (rst_n),
         .a     (a_q[i]),
         .b     (b_q[i]),
         .p     (prod[i])
      );
   end

   // --------------------
   // Adder tree
   // --------------------

   // Level one adds neighbouring products
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int k = 0; k < vec_len/2; k++) begin
            pair_q[k] <= '0;
         end
      end else begin
         for (int k = 0; k < vec_len/2; k++) begin
            // Sign-extend before the add so the carry is kept
            pair_q[k] <= (prod_w+1)'(prod[2*k]) + (prod_w+1)'(prod[2*k+1]);
         end
      end
   end

   // Level two joins the two pair sums
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tree_sum <= '0;
      end else begin
         tree_sum <= sum_t'(pair_q[0]) + sum_t'(pair_q[1]);
      end
   end

endmodule

`default_nettype wire

// File: src/sat_combine.sv
// Adds the tree sum to the aligned accumulator and clamps to the 32-bit signed range
`timescale 1ns/1ps
`default_nettype none

module sat_combine
   import dot_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n,
   input  sum_t  tree_sum,
   input  acc_t  acc_al,
   input  wire   valid_al,
   output logic  wr_valid,
   output acc_t  wr_data
);

   wide_t sum_wide;
   logic  pos_ovf;
   logic  neg_ovf;
   acc_t  sat_val;

   // Wide add, both sides sign-extended
   assign sum_wide = wide_t'(tree_sum) + wide_t'(acc_al);

   // Bits above the result sign must all copy the wide sign bit
   assign pos_ovf = !sum_wide[wide_w-1] && (sum_wide[wide_w-2:acc_w-1] != '0);
   assign neg_ovf = sum_wide[wide_w-1] && (sum_wide[wide_w-2:acc_w-1] != '1);

   // --------------------
   // Clamp
   // --------------------
   always_comb begin
      if (pos_ovf) begin
         sat_val = {1'b0, {(acc_w-1){1'b1}}};
      end else if (neg_ovf) begin
         sat_val = {1'b1, {(acc_w-1){1'b0}}};
      end else begin
         sat_val = sum_wide[acc_w-1:0];
      end
   end

   // Valid flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_valid <= 1'b0;
      end else begin
         wr_valid <= valid_al;
      end
   end

   // Result word, qualified by wr_valid
   always_ff @(posedge clk) begin
      wr_data <= sat_val;
   end

endmodule

`default_nettype wire

// File: src/result_credit_buf.sv
// Result FIFO with a downstream credit counter and upstream credit return
`timescale 1ns/1ps
`default_nettype none

module result_credit_buf
   import dot_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n,
   input  wire   wr_valid,
   input  acc_t  wr_data,
   input  wire   out_credit,
   output logic  out_valid,
   output acc_t  result,
   output logic  in_credit
);

   // Storage
   acc_t mem [result_depth];

   logic [fifo_aw-1:0] wr_ptr;
   logic [fifo_aw-1:0] rd_ptr;
   // Entries currently held
   logic [fifo_aw:0]   count;

   // Credits granted by the sink and not yet used
   logic [credit_w-1:0] credit_cnt;

   logic empty;
   logic pop;

   assign empty = (count == '0);
   // Send whenever something is waiting and the sink has room
   assign pop = !empty && (credit_cnt != '0);

   // --------------------
   // Outputs
   // --------------------
   assign out_valid = pop;
   assign result    = mem[rd_ptr];
   // Each departure frees one slot for the source
   assign in_credit = pop;

   // Write side, no reset on the array
   always_ff @(posedge clk) begin
      if (wr_valid) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // --------------------
   // Pointers and fill level
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= (wr_ptr == fifo_aw'(result_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == fifo_aw'(result_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Source credits keep the write side from overrunning
         case ({wr_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // --------------------
   // Downstream credits
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= credit_w'(down_credits);
      end else begin
         // Return and spend may land in the same cycle
         credit_cnt <= credit_cnt + credit_w'(out_credit) - credit_w'(pop);
      end
   end

endmodule

`default_nettype wire

// File: src/dot_unit_top.sv
// Top level of the pipelined dot-product unit with credit-based flow control
`timescale 1ns/1ps
`default_nettype none

module dot_unit_top
   import dot_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n,
   input  wire   in_valid,
   input  vec_t  a_vec,
   input  vec_t  b_vec,
   input  acc_t  acc_in,
   output logic  in_credit,
   output logic  out_valid,
   output acc_t  result,
   input  wire   out_credit
);

   sum_t tree_sum;
   // Accumulator and valid, lined up with tree_sum
   acc_t acc_al;
   logic valid_al;
   // Combine stage to buffer
   logic wr_valid;
   acc_t wr_data;

   // --------------------
   // Datapath
   // --------------------
   product_tree u_tree (
      .clk      (clk),
      .rst_n    (rst_n),
      .a_vec    (a_vec),
      .b_vec    (b_vec),
      .tree_sum (tree_sum)
   );

   // --------------------
   // Alignment path
   // --------------------
   pipe_delay #(.DEPTH(pipe_latency - 1), .payload_t(acc_t)) u_acc_dly (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (acc_in),
      .q     (acc_al)
   );

   // Same depth for the valid bit
   pipe_delay #(.DEPTH(pipe_latency - 1), .payload_t(logic)) u_vld_dly (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (in_valid),
      .q     (valid_al)
   );

   // Sum and clamp
   sat_combine u_sat (
      .clk      (clk),
      .rst_n    (rst_n),
      .tree_sum (tree_sum),
      .acc_al   (acc_al),
      .valid_al (valid_al),
      .wr_valid (wr_valid),
      .wr_data  (wr_data)
   );

   // Buffer and credits on both sides
   result_credit_buf u_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_valid   (wr_valid),
      .wr_data    (wr_data),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .result     (result),
      .in_credit  (in_credit)
   );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// Free-running testbench clock source, 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter real period_ns = 4.0
) (
   output logic clk
);

   // Low at time zero, then toggle every half period
   initial begin
      clk = 1'b0;
      forever begin
         #(period_ns / 2.0) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// File: bench/dot_unit_tb.sv
// Table-driven testbench for the dot-product unit with credit models on both sides
`timescale 1ns/1ps
`default_nettype none

module dot_unit_tb
   import dot_pkg::*;
;

   localparam int n_table = 10;
   localparam int n_random = 16;
   localparam int wait_limit = 200;
   localparam longint sat_hi = 64'sh7FFF_FFFF;
   localparam longint sat_lo = -64'sh8000_0000;

   // DUT signals
   logic clk;
   logic rst_n;
   logic in_valid;
   vec_t a_vec;
   vec_t b_vec;
   acc_t acc_in;
   logic in_credit;
   logic out_valid;
   acc_t result;
   logic out_credit;

   // Stimulus table
   vec_t   tbl_a [n_table];
   vec_t   tbl_b [n_table];
   acc_t   tbl_acc [n_table];
   longint tbl_exp [n_table];
   string  tbl_name [n_table];
   int     tbl_fill;

   // Results still owed by the DUT in send order
   longint exp_q [$];
   string  name_q [$];

   // Credit bookkeeping
   int upcred;
   int pending_ret;
   int pulse_count;
   logic grant_en;
   integer seed;

   // Monitor scratch
   longint mon_exp;
   string  mon_name;

   tb_clock_gen clk_gen (.clk(clk));

   dot_unit_top dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .a_vec      (a_vec),
      .b_vec      (b_vec),
      .acc_in     (acc_in),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .result     (result),
      .out_credit (out_credit)
   );

   // --------------------
   // Helpers
   // --------------------

   // Sum of signed element products plus accumulator clamped to 32 bits
   function automatic longint expected_dot(input vec_t a, input vec_t b, input acc_t acc);
      longint total;
      total = longint'(acc);
      for (int i = 0; i < vec_len; i++) begin
         total = total + longint'(a[i]) * longint'(b[i]);
      end
      if (total > sat_hi) begin
         total = sat_hi;
      end else if (total < sat_lo) begin
         total = sat_lo;
      end
      return total;
   endfunction

   function automatic vec_t make_vec(input int e3, input int e2, input int e1, input int e0);
      return {elem_t'(e3), elem_t'(e2), elem_t'(e1), elem_t'(e0)};
   endfunction

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "Stopping at first failure");
   endtask

   task automatic check_val(input string name, input longint expv, input longint actv);
      if (expv != actv) begin
         report_failure($sformatf("mismatch %s expected %0d actual %0d", name, expv, actv));
      end
   endtask

   task automatic add_entry(input string name, input vec_t a, input vec_t b, input acc_t acc);
      tbl_name[tbl_fill] = name;
      tbl_a[tbl_fill]    = a;
      tbl_b[tbl_fill]    = b;
      tbl_acc[tbl_fill]  = acc;
      tbl_exp[tbl_fill]  = expected_dot(a, b, acc);
      tbl_fill++;
   endtask

   task automatic build_table();
      tbl_fill = 0;
      // Mixed signs and small accumulators
      add_entry("mixed_small", make_vec(1, -2, 3, -4), make_vec(5, 6, -7, 8), 10);
      add_entry("mixed_neg_acc", make_vec(-10, 20, -30, 40), make_vec(3, -3, 3, -3), -100);
      add_entry("zero_vectors", make_vec(0, 0, 0, 0), make_vec(0, 0, 0, 0), 12345);
      add_entry("extreme_mix", make_vec(127, -128, 127, -128),
                make_vec(-128, 127, 127, -128), 0);
      add_entry("unit_cancel", make_vec(1, 1, 1, 1), make_vec(-1, -1, -1, -1), 4);
      // Lands exactly on the positive limit without clamping
      add_entry("edge_pos_exact", make_vec(-128, -128, -128, -128),
                make_vec(-128, -128, -128, -128), 2147418111);
      // Saturation both ways
      add_entry("sat_pos", make_vec(-128, -128, -128, -128),
                make_vec(-128, -128, -128, -128), 2147483000);
      add_entry("sat_pos_acc_max", make_vec(1, 1, 1, 1), make_vec(1, 1, 1, 1), 2147483647);
      add_entry("sat_neg", make_vec(-128, -128, -128, -128),
                make_vec(127, 127, 127, 127), -2147483000);
      add_entry("sat_neg_acc_min", make_vec(0, 0, 0, 1), make_vec(0, 0, 0, -1),
                32'sh8000_0000);
   endtask

   // Called at posedge plus 1 ns and returns at the next posedge plus 1 ns
   task automatic send_item(input string name, input vec_t a, input vec_t b, input acc_t acc,
                            input longint expv);
      int waited;
      waited = 0;
      while (upcred == 0) begin
         in_valid = 1'b0;
         @(posedge clk);
         #1;
         waited++;
         if (waited > wait_limit) begin
            report_failure("timed out waiting for an upstream credit to return");
         end
      end
      in_valid = 1'b1;
      a_vec    = a;
      b_vec    = b;
      acc_in   = acc;
      upcred--;
      exp_q.push_back(expv);
      name_q.push_back(name);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   // Waits until every result is back and every credit returned
   task automatic wait_idle(input string what);
      int waited;
      waited = 0;
      @(posedge clk);
      while (exp_q.size() != 0 || pending_ret != 0 || upcred != result_depth) begin
         @(posedge clk);
         waited++;
         if (waited > wait_limit) begin
            report_failure($sformatf("timed out waiting for %s to drain", what));
         end
      end
      #1;
   endtask

   task automatic wait_pulses(input int target);
      int waited;
      waited = 0;
      @(posedge clk);
      while (pulse_count < target) begin
         @(posedge clk);
         waited++;
         if (waited > wait_limit) begin
            report_failure("timed out waiting for out_valid while downstream credits were held");
         end
      end
      #1;
   endtask

   // --------------------
   // Output monitor
   // --------------------

   // Samples mid-cycle where DUT outputs are settled
   always @(negedge clk) begin
      if (rst_n) begin
         check_val("in_credit follows out_valid", longint'(out_valid), longint'(in_credit));
         if (out_valid) begin
            if (exp_q.size() == 0) begin
               report_failure("out_valid came with no result outstanding");
            end
            mon_exp  = exp_q.pop_front();
            mon_name = name_q.pop_front();
            check_val(mon_name, mon_exp, longint'(result));
            pulse_count++;
            // Sink consumes at once and owes a credit
            pending_ret++;
         end
         if (in_credit) begin
            upcred++;
            if (upcred > result_depth) begin
               report_failure("upstream credit count rose above the FIFO depth");
            end
         end
      end
   end

   // Downstream sink hands credits back one per cycle
   initial begin : credit_return
      out_credit = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (rst_n && grant_en && pending_ret > 0) begin
            out_credit = 1'b1;
            pending_ret--;
         end else begin
            out_credit = 1'b0;
         end
      end
   end

   // --------------------
   // Main sequence
   // --------------------
   initial begin : main_seq
      int n;
      int base;
      logic seen;
      vec_t ra;
      vec_t rb;
      acc_t racc;

      rst_n       = 1'b0;
      in_valid    = 1'b0;
      a_vec       = '0;
      b_vec       = '0;
      acc_in      = '0;
      upcred      = result_depth;
      pending_ret = 0;
      pulse_count = 0;
      grant_en    = 1'b1;
      seed        = 33960;
      build_table();

      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Quiet after reset
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         check_val("idle out_valid", 0, longint'(out_valid));
         check_val("idle in_credit", 0, longint'(in_credit));
      end
      @(posedge clk);
      #1;

      // Latency with an empty FIFO and credits held
      send_item("latency_item", make_vec(2, 3, 4, 5), make_vec(1, 1, 1, 1), 7, 21);
      n = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk);
         n++;
         seen = out_valid;
         if (n > wait_limit) begin
            report_failure("timed out waiting for out_valid of the latency item");
         end
      end
      check_val("latency_cycles", 7, n);
      wait_idle("latency item");

      // Table entries sent back to back
      for (int i = 0; i < n_table; i++) begin
         send_item(tbl_name[i], tbl_a[i], tbl_b[i], tbl_acc[i], tbl_exp[i]);
      end
      wait_idle("table entries");

      // Back-pressure while the sink keeps its credits
      grant_en = 1'b0;
      base = pulse_count;
      for (int i = 0; i < result_depth; i++) begin
         send_item($sformatf("held_%0d", i), tbl_a[i], tbl_b[i], tbl_acc[i] + i,
                   expected_dot(tbl_a[i], tbl_b[i], tbl_acc[i] + i));
      end
      wait_pulses(base + down_credits);
      repeat (30) @(posedge clk);
      #1;
      check_val("pulses_while_held", down_credits, pulse_count - base);
      grant_en = 1'b1;
      wait_idle("held results");

      // Random entries at full credit rate
      for (int i = 0; i < n_random; i++) begin
         ra   = $random(seed);
         rb   = $random(seed);
         racc = $random(seed);
         send_item($sformatf("random_%0d", i), ra, rb, racc, expected_dot(ra, rb, racc));
      end
      wait_idle("random entries");

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
src/dot_pkg.sv
src/pipe_delay.sv
src/mult_stage.sv
src/product_tree.sv
src/sat_combine.sv
src/result_credit_buf.sv
src/dot_unit_top.sv
bench/tb_clock_gen.sv
bench/dot_unit_tb.sv

// File: Makefile
# Verilator simulation of the dot-product unit

VERILATOR ?= verilator
TOP       ?= dot_unit_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
